//--- logic/exe_cluster.sv
`timescale 1ns/1ps
// results leave in program order; up to NUM_LANES instructions are in flight.
module exe_cluster (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_dec_req,
  output logic              o_dec_ack,
  input  exe_pkg::dec_pkt_t i_dec_pkt,
  output logic              o_res_req,
  output exe_pkg::res_pkt_t o_res_pkt,
  input  logic              i_res_ack
);
  import exe_pkg::*;

  logic [NUM_LANES-1:0] lane_dec_req;
  logic [NUM_LANES-1:0] lane_dec_ack;
  logic [NUM_LANES-1:0] lane_exe_req;
  logic [NUM_LANES-1:0] lane_exe_ack;
  res_pkt_t             lane_res [NUM_LANES];

  exe_dispatch u_dispatch (
    .clk        (clk),
    .rst        (rst),
    .i_dec_req  (i_dec_req),
    .o_dec_ack  (o_dec_ack),
    .o_lane_req (lane_dec_req),
    .i_lane_ack (lane_dec_ack)
  );

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    exe_stage u_stage (
      .clk            (clk),
      .rst            (rst),
      .i_decoded_req  (lane_dec_req[g]),
      .o_decoded_ack  (lane_dec_ack[g]),
      .i_pkt          (i_dec_pkt),   // broadcast, only the selected lane captures.
      .o_executed_req (lane_exe_req[g]),
      .i_executed_ack (lane_exe_ack[g]),
      .o_res          (lane_res[g])
    );
  end

  exe_retire u_retire (
    .clk        (clk),
    .rst        (rst),
    .i_lane_req (lane_exe_req),
    .i_lane_res (lane_res),
    .o_lane_ack (lane_exe_ack),
    .o_res_req  (o_res_req),
    .o_res_pkt  (o_res_pkt),
    .i_res_ack  (i_res_ack)
  );

endmodule

//--- logic/exe_dispatch.sv
`timescale 1ns/1ps
// strict rotation; a busy lane at the pointer stalls decode even if others are free.
module exe_dispatch (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          i_dec_req,
  output logic                          o_dec_ack,
  output logic [exe_pkg::NUM_LANES-1:0] o_lane_req,
  input  logic [exe_pkg::NUM_LANES-1:0] i_lane_ack
);
  import exe_pkg::*;

  lane_idx_t wr_ptr;
  logic      dec_hs;

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      o_lane_req[i] = i_dec_req && (wr_ptr == lane_idx_t'(i));
    end
  end

  assign o_dec_ack = i_lane_ack[wr_ptr];
  assign dec_hs    = i_dec_req && o_dec_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (dec_hs) begin
      wr_ptr <= wr_ptr + lane_idx_t'(1);   // wraps, lane count is a power of two.
    end
  end

endmodule

//--- logic/exe_pkg.sv
// shared types and constants for the RV64I execute cluster.
// NUM_LANES must be a power of two, 2 or more; the lane pointers wrap on overflow.
package exe_pkg;

  localparam int NUM_LANES = 4;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  ridx_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;
  typedef logic [$clog2(NUM_LANES)-1:0] lane_idx_t;

  // major opcodes.
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;

  // branch conditions.
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // alu operations, sub and sra picked by funct7 bit 5.
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  typedef struct packed {
    xlen_t   pc;
    inst_t   inst;
    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    xlen_t   op1;     // rs1, or pc for auipc.
    xlen_t   op2;     // rs2 or immediate.
    xlen_t   t1;      // rs2 for branch/store, imm for jalr.
    ridx_t   rd;
  } dec_pkt_t;

  typedef struct packed {
    xlen_t   pc;
    inst_t   inst;
    ridx_t   rd;
    logic    rd_wen;
    xlen_t   rd_wdata;
    logic    pc_jmp;
    xlen_t   pc_jmpaddr;
    logic    memren;
    logic    memwen;
    xlen_t   mem_addr;
    xlen_t   mem_wdata;
  } res_pkt_t;

  typedef enum logic {
    LANE_IDLE,
    LANE_BUSY
  } lane_state_e;

endpackage

//--- logic/exe_retire.sv
`timescale 1ns/1ps
// in-order drain; a finished younger lane waits until the pointer reaches it.
module exe_retire (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [exe_pkg::NUM_LANES-1:0] i_lane_req,
  input  exe_pkg::res_pkt_t             i_lane_res [exe_pkg::NUM_LANES],
  output logic [exe_pkg::NUM_LANES-1:0] o_lane_ack,
  output logic                          o_res_req,
  output exe_pkg::res_pkt_t             o_res_pkt,
  input  logic                          i_res_ack
);
  import exe_pkg::*;

  lane_idx_t rd_ptr;
  logic      res_hs;

  assign o_res_req = i_lane_req[rd_ptr];
  assign o_res_pkt = i_lane_res[rd_ptr];
  assign res_hs    = o_res_req && i_res_ack;

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      o_lane_ack[i] = i_res_ack && (rd_ptr == lane_idx_t'(i));   // oldest lane only.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (res_hs) begin
      rd_ptr <= rd_ptr + lane_idx_t'(1);
    end
  end

endmodule

//--- logic/exe_stage.sv
`timescale 1ns/1ps
// one execute lane; holds a single instruction, so it accepts again only after
// its result has been taken.
module exe_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_decoded_req,
  output logic              o_decoded_ack,
  input  exe_pkg::dec_pkt_t i_pkt,
  output logic              o_executed_req,
  input  logic              i_executed_ack,
  output exe_pkg::res_pkt_t o_res
);
  import exe_pkg::*;

  lane_state_e state;
  dec_pkt_t    pkt_q;
  res_pkt_t    unit_res;

  assign o_decoded_ack  = (state == LANE_IDLE);
  assign o_executed_req = (state == LANE_BUSY);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= LANE_IDLE;
    end else begin
      case (state)
        LANE_IDLE: begin
          if (i_decoded_req) begin
            state <= LANE_BUSY;
          end
        end
        default: begin
          if (i_executed_ack) begin
            state <= LANE_IDLE;   // free again next cycle.
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_decoded_req && o_decoded_ack) begin
      pkt_q <= i_pkt;
    end
  end

  exe_unit u_exe_unit (
    .i_pkt (pkt_q),
    .o_res (unit_res)
  );

  // an idle lane shows all zeros, no stale jump or memory flags.
  assign o_res = o_executed_req ? unit_res : '0;

endmodule

//--- logic/exe_unit.sv
`timescale 1ns/1ps
// combinational; loads and stores only form the address, no memory access here.
// the word forms and the M extension are not decoded; unknown opcodes write nothing.
module exe_unit (
  input  exe_pkg::dec_pkt_t i_pkt,
  output exe_pkg::res_pkt_t o_res
);
  import exe_pkg::*;

  xlen_t      op1;
  xlen_t      op2;
  xlen_t      t1;
  xlen_t      alu_out;
  xlen_t      sra_out;
  xlen_t      link;
  xlen_t      jalr_sum;
  logic [5:0] shamt;
  logic       alt;
  logic       br_take;

  assign op1      = i_pkt.op1;
  assign op2      = i_pkt.op2;
  assign t1       = i_pkt.t1;
  assign shamt    = op2[5:0];
  assign alt      = i_pkt.funct7[5];   // sub / sra select.
  assign link     = i_pkt.pc + xlen_t'(4);
  assign jalr_sum = op1 + t1;
  assign sra_out  = $signed(op1) >>> shamt;   // kept apart so the shift stays signed.

  always_comb begin
    case (i_pkt.funct3)
      F3_ADD:  alu_out = (i_pkt.opcode == OPC_OP && alt) ? op1 - op2 : op1 + op2;
      F3_SLL:  alu_out = op1 << shamt;
      F3_SLT:  alu_out = xlen_t'($signed(op1) < $signed(op2));
      F3_SLTU: alu_out = xlen_t'(op1 < op2);
      F3_XOR:  alu_out = op1 ^ op2;
      F3_SR:   alu_out = alt ? sra_out : op1 >> shamt;
      F3_OR:   alu_out = op1 | op2;
      default: alu_out = op1 & op2;   // F3_AND.
    endcase
  end

  always_comb begin
    case (i_pkt.funct3)
      F3_BEQ:  br_take = (op1 == t1);
      F3_BNE:  br_take = (op1 != t1);
      F3_BLT:  br_take = ($signed(op1) < $signed(t1));
      F3_BGE:  br_take = ($signed(op1) >= $signed(t1));
      F3_BLTU: br_take = (op1 < t1);
      F3_BGEU: br_take = (op1 >= t1);
      default: br_take = 1'b0;
    endcase
  end

  always_comb begin
    o_res           = '0;
    o_res.pc        = i_pkt.pc;
    o_res.inst      = i_pkt.inst;
    o_res.rd        = i_pkt.rd;
    o_res.mem_addr  = op1 + op2;
    o_res.mem_wdata = t1;
    o_res.memren    = (i_pkt.opcode == OPC_LOAD);
    o_res.memwen    = (i_pkt.opcode == OPC_STORE);
    case (i_pkt.opcode)
      OPC_OP, OPC_OP_IMM: begin
        o_res.rd_wen   = 1'b1;
        o_res.rd_wdata = alu_out;
      end
      OPC_LUI: begin
        o_res.rd_wen   = 1'b1;
        o_res.rd_wdata = op2;
      end
      OPC_AUIPC: begin
        o_res.rd_wen   = 1'b1;
        o_res.rd_wdata = op1 + op2;
      end
      OPC_JAL: begin
        o_res.rd_wen     = 1'b1;
        o_res.rd_wdata   = link;
        o_res.pc_jmp     = 1'b1;
        o_res.pc_jmpaddr = i_pkt.pc + op2;
      end
      OPC_JALR: begin
        o_res.rd_wen     = 1'b1;
        o_res.rd_wdata   = link;
        o_res.pc_jmp     = 1'b1;
        o_res.pc_jmpaddr = jalr_sum & ~xlen_t'(1);
      end
      OPC_BRANCH: begin
        o_res.pc_jmp     = br_take;
        o_res.pc_jmpaddr = br_take ? i_pkt.pc + op2 : '0;   // zero when not taken.
      end
      OPC_LOAD: begin
        o_res.rd_wen = 1'b1;   // data comes from the memory stage.
      end
      default: begin
      end
    endcase
    if (i_pkt.rd == '0) begin
      o_res.rd_wen = 1'b0;   // x0 is never written.
    end
  end

endmodule

//--- tests/exe_cluster_checker.sv
`timescale 1ns/1ps
// samples on the falling edge; a transfer seen there completes at the next rising edge.
// expected results are pushed by the testbench in program order.
module exe_cluster_checker (
  input logic              clk,
  input logic              rst,
  input logic              i_dec_req,
  input logic              i_dec_ack,
  input logic              i_res_req,
  input exe_pkg::res_pkt_t i_res_pkt,
  input logic              i_res_ack
);
  import exe_pkg::*;

  res_pkt_t exp_q[$];
  int       errors = 0;
  int       checks = 0;
  int       in_flight = 0;
  logic     rst_q = 1'b1;

  task automatic push_expected(input res_pkt_t exp);
    exp_q.push_back(exp);
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  task automatic compare_field(input string name, input xlen_t got, input xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_result(input res_pkt_t got);
    res_pkt_t exp;
    if (exp_q.size() == 0) begin
      errors++;
      $display("result for pc %h retired with no instruction waiting for it", got.pc);
      return;
    end
    exp = exp_q.pop_front();
    compare_field("pc", got.pc, exp.pc);
    compare_field("inst", xlen_t'(got.inst), xlen_t'(exp.inst));
    compare_field("rd", xlen_t'(got.rd), xlen_t'(exp.rd));
    compare_field("rd_wen", xlen_t'(got.rd_wen), xlen_t'(exp.rd_wen));
    compare_field("rd_wdata", got.rd_wdata, exp.rd_wdata);
    compare_field("pc_jmp", xlen_t'(got.pc_jmp), xlen_t'(exp.pc_jmp));
    compare_field("pc_jmpaddr", got.pc_jmpaddr, exp.pc_jmpaddr);
    compare_field("memren", xlen_t'(got.memren), xlen_t'(exp.memren));
    compare_field("memwen", xlen_t'(got.memwen), xlen_t'(exp.memwen));
    compare_field("mem_addr", got.mem_addr, exp.mem_addr);
    compare_field("mem_wdata", got.mem_wdata, exp.mem_wdata);
  endtask

  always @(negedge clk) begin
    if (rst_q && !rst) begin   // first cycle out of reset.
      compare_field("o_res_req after reset", xlen_t'(i_res_req), '0);
      compare_field("o_dec_ack after reset", xlen_t'(i_dec_ack), xlen_t'(1));
    end
    if (!rst) begin
      if (in_flight == NUM_LANES) begin
        compare_field("o_dec_ack with all lanes full", xlen_t'(i_dec_ack), '0);
      end
      if (i_res_req && i_res_ack) begin
        compare_result(i_res_pkt);
        in_flight--;
      end
      if (i_dec_req && i_dec_ack) begin
        in_flight++;
      end
    end
    rst_q <= rst;
  end

endmodule

//--- tests/exe_cluster_tb.sv
`timescale 1ns/1ps
// runs the table once with random result back-pressure, then a lane-fill phase.
module exe_cluster_tb;
  import exe_pkg::*;

  localparam int NUM_ROWS = 30;
  localparam int TIMEOUT  = 200;
  localparam xlen_t M1    = 64'hffff_ffff_ffff_ffff;

  logic     clk = 1'b0;
  logic     rst = 1'b1;
  logic     i_dec_req = 1'b0;
  logic     o_dec_ack;
  dec_pkt_t i_dec_pkt = '0;
  logic     o_res_req;
  res_pkt_t o_res_pkt;
  logic     i_res_ack = 1'b0;
  integer   seed = 32'h60f6;
  int       ack_mode = 1;   // 0 random, 1 held low, 2 held high.
  int       tb_errors = 0;
  int       n_rows = 0;
  dec_pkt_t rows [NUM_ROWS];
  res_pkt_t exp_rows [NUM_ROWS];

  always #20 clk = ~clk;

  exe_cluster i_dut (.clk(clk), .rst(rst), .i_dec_req(i_dec_req), .o_dec_ack(o_dec_ack),
    .i_dec_pkt(i_dec_pkt), .o_res_req(o_res_req), .o_res_pkt(o_res_pkt), .i_res_ack(i_res_ack));

  exe_cluster_checker i_chk (.clk(clk), .rst(rst), .i_dec_req(i_dec_req),
    .i_dec_ack(o_dec_ack), .i_res_req(o_res_req), .i_res_pkt(o_res_pkt), .i_res_ack(i_res_ack));

  always @(posedge clk) begin
    if (ack_mode == 0) i_res_ack <= #1 1'($random(seed));
    else i_res_ack <= #1 (ack_mode == 2);
  end

  task automatic add_row(input opcode_t opc, input funct3_t f3, input funct7_t f7,
                         input xlen_t op1, input xlen_t op2, input xlen_t t1, input ridx_t rd,
                         input logic wen, input xlen_t wdata, input logic jmp, input xlen_t jaddr,
                         input logic [1:0] mem, input xlen_t maddr);   // mem is {read, write}.
    dec_pkt_t d;
    res_pkt_t e;
    d = '{pc: 64'h1000 + 4 * n_rows, inst: 32'h0013_0000 + n_rows, opcode: opc, funct3: f3,
          funct7: f7, op1: op1, op2: op2, t1: t1, rd: rd};
    e = '{pc: d.pc, inst: d.inst, rd: rd, rd_wen: wen, rd_wdata: wdata, pc_jmp: jmp,
          pc_jmpaddr: jaddr, memren: mem[1], memwen: mem[0], mem_addr: maddr,
          mem_wdata: t1};
    rows[n_rows] = d;
    exp_rows[n_rows] = e;
    n_rows++;
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  // called a little after a rising edge, returns at the same point.
  task automatic send_row(input int k);
    int tries;
    tries = 0;
    i_dec_req = 1'b1;
    i_dec_pkt = rows[k];
    do begin
      @(negedge clk);
      tries++;
      if (tries > TIMEOUT) fail_timeout("o_dec_ack");
    end while (!o_dec_ack);
    i_chk.push_expected(exp_rows[k]);
    @(posedge clk);
    #1;
    i_dec_req = 1'b0;
  endtask

  // returns a little after the edge of the last transfer.
  task automatic drain();
    int tries;
    tries = 0;
    while (i_chk.pending() != 0) begin
      @(posedge clk);
      tries++;
      if (tries > TIMEOUT) fail_timeout("results to retire");
    end
    #1;
  endtask

  initial begin
    add_row(OPC_OP, F3_ADD, 7'h00, 5, 7, 0, 1, 1, 12, 0, 0, 0, 12);
    add_row(OPC_OP, F3_ADD, 7'h20, 5, 7, 0, 1, 1, 64'hffff_ffff_ffff_fffe, 0, 0, 0, 12);
    add_row(OPC_OP_IMM, F3_ADD, 7'h20, 10, M1, 0, 2, 1, 9, 0, 0, 0, 9);
    add_row(OPC_OP, F3_SLL, 7'h00, 1, 63, 0, 3, 1, 64'h8000_0000_0000_0000, 0, 0, 0, 64'h40);
    add_row(OPC_OP, F3_SLT, 7'h00, M1, 1, 0, 4, 1, 1, 0, 0, 0, 0);
    add_row(OPC_OP, F3_SLTU, 7'h00, M1, 1, 0, 4, 1, 0, 0, 0, 0, 0);
    add_row(OPC_OP_IMM, F3_XOR, 7'h00, 64'hff, 64'h0f, 0, 5, 1, 64'hf0, 0, 0, 0, 64'h10e);
    add_row(OPC_OP, F3_SR, 7'h00, 64'h8000_0000_0000_0000, 4, 0, 6, 1,
            64'h0800_0000_0000_0000, 0, 0, 0, 64'h8000_0000_0000_0004);
    add_row(OPC_OP_IMM, F3_SR, 7'h20, 64'h8000_0000_0000_0000, 4, 0, 6, 1,
            64'hf800_0000_0000_0000, 0, 0, 0, 64'h8000_0000_0000_0004);
    add_row(OPC_OP, F3_OR, 7'h00, 64'hf0, 64'h0f, 0, 7, 1, 64'hff, 0, 0, 0, 64'hff);
    add_row(OPC_OP_IMM, F3_AND, 7'h00, 64'hff, 64'h3c, 0, 7, 1, 64'h3c, 0, 0, 0, 64'h13b);
    add_row(OPC_LUI, 3'd0, 7'h00, 0, 64'h1234_5000, 0, 8, 1, 64'h1234_5000, 0, 0, 0,
            64'h1234_5000);
    add_row(OPC_AUIPC, 3'd0, 7'h00, 64'h1030, 64'h1000, 0, 8, 1, 64'h2030, 0, 0, 0, 64'h2030);
    add_row(OPC_OP, F3_ADD, 7'h00, 1, 2, 0, 0, 0, 3, 0, 0, 0, 3);   // rd 0 is not written.
    add_row(OPC_BRANCH, F3_BEQ, 7'h00, 3, 64'h40, 3, 2, 0, 0, 1, 64'h1078, 0, 64'h43);
    add_row(OPC_BRANCH, F3_BEQ, 7'h00, 3, 64'h40, 4, 2, 0, 0, 0, 0, 0, 64'h43);
    add_row(OPC_BRANCH, F3_BNE, 7'h00, 3, 64'h40, 4, 2, 0, 0, 1, 64'h1080, 0, 64'h43);
    add_row(OPC_BRANCH, F3_BLT, 7'h00, M1, 64'h40, 1, 2, 0, 0, 1, 64'h1084, 0, 64'h3f);
    add_row(OPC_BRANCH, F3_BGE, 7'h00, M1, 64'h40, 1, 2, 0, 0, 0, 0, 0, 64'h3f);
    add_row(OPC_BRANCH, F3_BLTU, 7'h00, M1, 64'h40, 1, 2, 0, 0, 0, 0, 0, 64'h3f);
    add_row(OPC_BRANCH, F3_BGEU, 7'h00, M1, 64'h40, 1, 2, 0, 0, 1, 64'h1090, 0, 64'h3f);
    add_row(OPC_JAL, 3'd0, 7'h00, 0, 64'h100, 0, 1, 1, 64'h1058, 1, 64'h1154, 0, 64'h100);
    add_row(OPC_JALR, 3'd0, 7'h00, 64'h2001, 0, 64'h10, 1, 1, 64'h105c, 1, 64'h2010, 0,
            64'h2001);
    add_row(OPC_LOAD, 3'd3, 7'h00, 64'h3000, 8, 0, 5, 1, 0, 0, 0, 2'b10, 64'h3008);
    add_row(OPC_STORE, 3'd3, 7'h00, 64'h3000, M1 - 7, 64'hdead, 7, 0, 0, 0, 0, 2'b01,
            64'h2ff8);
    // other outcome of each branch.
    add_row(OPC_BRANCH, F3_BNE, 7'h00, 3, 64'h40, 3, 2, 0, 0, 0, 0, 0, 64'h43);
    add_row(OPC_BRANCH, F3_BLT, 7'h00, 1, 64'h40, M1, 2, 0, 0, 0, 0, 0, 64'h41);
    add_row(OPC_BRANCH, F3_BGE, 7'h00, 1, 64'h40, M1, 2, 0, 0, 1, 64'h10ac, 0, 64'h41);
    add_row(OPC_BRANCH, F3_BLTU, 7'h00, 1, 64'h40, M1, 2, 0, 0, 1, 64'h10b0, 0, 64'h41);
    add_row(OPC_BRANCH, F3_BGEU, 7'h00, 1, 64'h40, M1, 2, 0, 0, 0, 0, 0, 64'h41);

    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    ack_mode = 0;
    for (int k = 0; k < NUM_ROWS; k++) send_row(k);
    ack_mode = 2;
    drain();

    // fill every lane with the result side stalled.
    ack_mode = 1;
    for (int k = 0; k < NUM_LANES; k++) send_row(k);
    i_dec_req = 1'b1;
    i_dec_pkt = rows[NUM_LANES];
    repeat (10) begin
      @(negedge clk);
      if (o_dec_ack) begin
        tb_errors++;
        $display("CHECK FAILED at %0t: decode accepted with all lanes full", $time);
      end
    end
    ack_mode = 2;
    send_row(NUM_LANES);
    drain();

    $display("errors: %0d checker, %0d testbench, %0d checks",
             i_chk.errors, tb_errors, i_chk.checks);
    if (i_chk.errors == 0 && tb_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
logic/exe_pkg.sv
logic/exe_unit.sv
logic/exe_stage.sv
logic/exe_dispatch.sv
logic/exe_retire.sv
logic/exe_cluster.sv
tests/exe_cluster_checker.sv
tests/exe_cluster_tb.sv
